//--- logic/cluster_periph_pkg.sv
// shared bus types, register offsets and event layout, referenced by scoped names in every block
`default_nettype none

package cluster_periph_pkg;

  // bus widths; the id carries the requesting core index
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ID_W   = 4;

  // bounded by the width of the software event write mask
  localparam int unsigned MAX_CORES = 8;

  localparam int unsigned EVT_W    = 8;
  localparam int unsigned IRQ_ID_W = 5;

  // ****************************************
  // event vector layout
  // ****************************************
  localparam int unsigned EVT_ACC_LSB = 0;
  localparam int unsigned EVT_ACC_W   = 4;
  localparam int unsigned EVT_DMA_EVT = 4;
  localparam int unsigned EVT_DMA_IRQ = 5;
  localparam int unsigned EVT_TIMER   = 6;
  localparam int unsigned EVT_SW      = 7;

  typedef logic [EVT_W-1:0] evt_vec_t;

  // ****************************************
  // peripheral bus
  // ****************************************
  typedef struct packed {
    logic              req;
    logic [ADDR_W-1:0] addr;
    // low means write
    logic              wen;
    logic [DATA_W-1:0] wdata;
    logic [ID_W-1:0]   id;
  } periph_req_t;

  typedef struct packed {
    logic              gnt;
    logic              r_valid;
    logic [DATA_W-1:0] r_rdata;
    logic [ID_W-1:0]   r_id;
  } periph_rsp_t;

  // register offsets, only the low address byte is decoded
  typedef enum logic [7:0] {
    CTRL_EOC       = 8'h00,
    CTRL_FETCH_EN  = 8'h08,
    // one word per core from here on
    CTRL_BOOT_ADDR = 8'h40
  } ctrl_reg_e;

  typedef enum logic [7:0] {
    TIMER_CFG = 8'h00,
    TIMER_CNT = 8'h08,
    TIMER_CMP = 8'h10
  } timer_reg_e;

  typedef enum logic [7:0] {
    EU_MASK         = 8'h00,
    EU_BUFFER       = 8'h04,
    EU_BUFFER_CLEAR = 8'h08,
    EU_SW_EVENT     = 8'h0C
  } eu_reg_e;

endpackage

`default_nettype wire

//--- logic/cluster_ctrl_regs.sv
// control unit registers: end of computation, per-core fetch enables and boot addresses
`default_nettype none

module cluster_ctrl_regs #(
  parameter int unsigned                            NB_CORES  = 4,
  parameter logic [cluster_periph_pkg::ADDR_W-1:0] BOOT_ADDR = 32'h1C000000
) (
  input  logic                                                  clk_i,
  input  logic                                                  arst_n_i,
  input  logic                                                  fetch_en_i,
  input  cluster_periph_pkg::periph_req_t                       req_i,
  output cluster_periph_pkg::periph_rsp_t                       rsp_o,
  output logic                                                  eoc_o,
  output logic [NB_CORES-1:0]                                   fetch_enable_o,
  output logic [NB_CORES-1:0][cluster_periph_pkg::ADDR_W-1:0]   boot_addr_o
);

  logic                                  wr;
  logic [7:0]                            offset;
  logic [cluster_periph_pkg::DATA_W-1:0] rdata;
  logic                                  r_valid_q;
  logic [cluster_periph_pkg::ID_W-1:0]   r_id_q;
  logic [cluster_periph_pkg::DATA_W-1:0] r_rdata_q;

  assign wr     = req_i.req & ~req_i.wen;
  assign offset = req_i.addr[7:0];

  // read mux, boot addresses sit at base plus four per core
  always_comb begin
    rdata = '0;
    case (offset)
      cluster_periph_pkg::CTRL_EOC:      rdata[0] = eoc_o;
      cluster_periph_pkg::CTRL_FETCH_EN: rdata[NB_CORES-1:0] = fetch_enable_o;
      default: begin
        for (int i = 0; i < NB_CORES; i++) begin
          if (int'(offset) == int'(cluster_periph_pkg::CTRL_BOOT_ADDR) + 4 * i) begin
            rdata = boot_addr_o[i];
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      eoc_o          <= 1'b0;
      fetch_enable_o <= '0;
      boot_addr_o    <= {NB_CORES{BOOT_ADDR}};
      r_valid_q      <= 1'b0;
    end else begin
      r_valid_q <= req_i.req;
      if (wr && offset == cluster_periph_pkg::CTRL_EOC) begin
        eoc_o <= req_i.wdata[0];
      end
      // external fetch enable overrides a bus write in the same cycle
      if (fetch_en_i) begin
        fetch_enable_o <= '1;
      end else if (wr && offset == cluster_periph_pkg::CTRL_FETCH_EN) begin
        fetch_enable_o <= req_i.wdata[NB_CORES-1:0];
      end
      for (int i = 0; i < NB_CORES; i++) begin
        if (wr && int'(offset) == int'(cluster_periph_pkg::CTRL_BOOT_ADDR) + 4 * i) begin
          boot_addr_o[i] <= req_i.wdata;
        end
      end
    end
  end

  // response payload, writes return zero
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      r_id_q    <= req_i.id;
      r_rdata_q <= req_i.wen ? rdata : '0;
    end
  end

  assign rsp_o.gnt     = req_i.req;
  assign rsp_o.r_valid = r_valid_q;
  assign rsp_o.r_rdata = r_rdata_q;
  assign rsp_o.r_id    = r_id_q;

endmodule

`default_nettype wire

//--- logic/cluster_timer_regs.sv
// timer configuration and compare registers, with bus read-back of the live count
`default_nettype none

module cluster_timer_regs (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  cluster_periph_pkg::periph_req_t       req_i,
  input  logic [cluster_periph_pkg::DATA_W-1:0] count_i,
  output cluster_periph_pkg::periph_rsp_t       rsp_o,
  output logic                                  enable_o,
  output logic                                  clear_o,
  output logic [cluster_periph_pkg::DATA_W-1:0] cmp_o
);

  logic                                  wr;
  logic [7:0]                            offset;
  logic [cluster_periph_pkg::DATA_W-1:0] rdata;
  logic                                  r_valid_q;
  logic [cluster_periph_pkg::ID_W-1:0]   r_id_q;
  logic [cluster_periph_pkg::DATA_W-1:0] r_rdata_q;

  assign wr     = req_i.req & ~req_i.wen;
  assign offset = req_i.addr[7:0];

  // cfg bit 1 clears the count at the granting edge, it is not stored
  assign clear_o = wr && offset == cluster_periph_pkg::TIMER_CFG && req_i.wdata[1];

  always_comb begin
    rdata = '0;
    case (offset)
      cluster_periph_pkg::TIMER_CFG: rdata[0] = enable_o;
      cluster_periph_pkg::TIMER_CNT: rdata = count_i;
      cluster_periph_pkg::TIMER_CMP: rdata = cmp_o;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable_o  <= 1'b0;
      cmp_o     <= '0;
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= req_i.req;
      if (wr && offset == cluster_periph_pkg::TIMER_CFG) begin
        enable_o <= req_i.wdata[0];
      end
      if (wr && offset == cluster_periph_pkg::TIMER_CMP) begin
        cmp_o <= req_i.wdata;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      r_id_q    <= req_i.id;
      r_rdata_q <= req_i.wen ? rdata : '0;
    end
  end

  assign rsp_o.gnt     = req_i.req;
  assign rsp_o.r_valid = r_valid_q;
  assign rsp_o.r_rdata = r_rdata_q;
  assign rsp_o.r_id    = r_id_q;

endmodule

`default_nettype wire

//--- logic/cluster_timer_counter.sv
// tick-driven timer counter, wraps on compare match and pulses the timer event
`default_nettype none

module cluster_timer_counter (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic                                  enable_i,
  input  logic                                  clear_i,
  input  logic                                  tick_i,
  input  logic [cluster_periph_pkg::DATA_W-1:0] cmp_i,
  output logic [cluster_periph_pkg::DATA_W-1:0] count_o,
  output logic                                  event_o,
  output logic                                  busy_o
);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_o <= '0;
      event_o <= 1'b0;
    end else begin
      event_o <= 1'b0;
      if (clear_i) begin
        count_o <= '0;
      end else if (enable_i && tick_i) begin
        // compare value is the last count before wrapping
        if (count_o == cmp_i) begin
          count_o <= '0;
          event_o <= 1'b1;
        end else begin
          count_o <= count_o + 1'b1;
        end
      end
    end
  end

  assign busy_o = enable_i;

endmodule

`default_nettype wire

//--- logic/event_unit_regs.sv
// event unit bus side: merges two plugs, holds per-core masks, issues clears and sw events
`default_nettype none

module event_unit_regs #(
  parameter int unsigned NB_CORES = 4
) (
  input  logic                                             clk_i,
  input  logic                                             arst_n_i,
  input  cluster_periph_pkg::periph_req_t [1:0]            plug_req_i,
  input  cluster_periph_pkg::evt_vec_t [NB_CORES-1:0]      buffer_i,
  output cluster_periph_pkg::periph_rsp_t [1:0]            plug_rsp_o,
  output cluster_periph_pkg::evt_vec_t [NB_CORES-1:0]      mask_o,
  output cluster_periph_pkg::evt_vec_t [NB_CORES-1:0]      clear_o,
  output logic [NB_CORES-1:0]                              sw_evt_o
);

  cluster_periph_pkg::periph_req_t          req;
  logic                                     sel1;
  logic                                     wr;
  logic [7:0]                               offset;
  logic [cluster_periph_pkg::MAX_CORES-1:0] sw_mask;
  logic [cluster_periph_pkg::DATA_W-1:0]    rdata;
  logic                                     valid_q;
  logic                                     sel1_q;
  logic [cluster_periph_pkg::ID_W-1:0]      id_q;
  logic [cluster_periph_pkg::DATA_W-1:0]    rdata_q;

  // ****************************************
  // plug merge
  // ****************************************
  // plug 1 only gets through when plug 0 is idle
  assign sel1   = plug_req_i[1].req & ~plug_req_i[0].req;
  assign req    = sel1 ? plug_req_i[1] : plug_req_i[0];
  assign wr     = req.req & ~req.wen;
  assign offset = req.addr[7:0];

  // one bit per target core
  assign sw_mask = req.wdata[cluster_periph_pkg::MAX_CORES-1:0];

  // ****************************************
  // decode, keyed on the requesting core
  // ****************************************
  always_comb begin
    rdata = '0;
    for (int i = 0; i < NB_CORES; i++) begin
      clear_o[i]  = '0;
      sw_evt_o[i] = wr && offset == cluster_periph_pkg::EU_SW_EVENT && sw_mask[i];
      if (int'(req.id) == i) begin
        if (wr && offset == cluster_periph_pkg::EU_BUFFER_CLEAR) begin
          clear_o[i] = req.wdata[cluster_periph_pkg::EVT_W-1:0];
        end
        case (offset)
          cluster_periph_pkg::EU_MASK:   rdata[cluster_periph_pkg::EVT_W-1:0] = mask_o[i];
          cluster_periph_pkg::EU_BUFFER: rdata[cluster_periph_pkg::EVT_W-1:0] = buffer_i[i];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mask_o  <= '0;
      valid_q <= 1'b0;
      sel1_q  <= 1'b0;
    end else begin
      valid_q <= req.req;
      sel1_q  <= sel1;
      for (int i = 0; i < NB_CORES; i++) begin
        if (wr && offset == cluster_periph_pkg::EU_MASK && int'(req.id) == i) begin
          mask_o[i] <= req.wdata[cluster_periph_pkg::EVT_W-1:0];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req.req) begin
      id_q    <= req.id;
      rdata_q <= req.wen ? rdata : '0;
    end
  end

  // response goes back only to the plug that was granted
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      plug_rsp_o[p].gnt     = (p == 1) ? sel1 : plug_req_i[0].req;
      plug_rsp_o[p].r_valid = valid_q && (sel1_q == (p == 1));
      plug_rsp_o[p].r_rdata = rdata_q;
      plug_rsp_o[p].r_id    = id_q;
    end
  end

endmodule

`default_nettype wire

//--- logic/event_unit_core.sv
// per-core event buffers with masked lowest-index interrupt selection and acknowledge
`default_nettype none

module event_unit_core #(
  parameter int unsigned NB_CORES = 4
) (
  input  logic                                                  clk_i,
  input  logic                                                  arst_n_i,
  input  cluster_periph_pkg::evt_vec_t [NB_CORES-1:0]           evt_set_i,
  input  logic [NB_CORES-1:0]                                   sw_evt_i,
  input  cluster_periph_pkg::evt_vec_t [NB_CORES-1:0]           clear_i,
  input  cluster_periph_pkg::evt_vec_t [NB_CORES-1:0]           mask_i,
  input  logic [NB_CORES-1:0]                                   irq_ack_i,
  input  logic [NB_CORES-1:0][cluster_periph_pkg::IRQ_ID_W-1:0] irq_ack_id_i,
  output cluster_periph_pkg::evt_vec_t [NB_CORES-1:0]           buffer_o,
  output logic [NB_CORES-1:0]                                   irq_req_o,
  output logic [NB_CORES-1:0][cluster_periph_pkg::IRQ_ID_W-1:0] irq_id_o
);

  cluster_periph_pkg::evt_vec_t [NB_CORES-1:0] buffer_d;
  cluster_periph_pkg::evt_vec_t [NB_CORES-1:0] pending;

  // clears and acks first, then new events on top so a set always wins
  always_comb begin
    for (int c = 0; c < NB_CORES; c++) begin
      buffer_d[c] = buffer_o[c] & ~clear_i[c];
      for (int b = 0; b < cluster_periph_pkg::EVT_W; b++) begin
        if (irq_ack_i[c] && int'(irq_ack_id_i[c]) == b) begin
          buffer_d[c][b] = 1'b0;
        end
      end
      buffer_d[c] = buffer_d[c] | evt_set_i[c];
      buffer_d[c][cluster_periph_pkg::EVT_SW] = buffer_d[c][cluster_periph_pkg::EVT_SW]
                                                | sw_evt_i[c];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      buffer_o <= '0;
    end else begin
      buffer_o <= buffer_d;
    end
  end

  // ****************************************
  // interrupt selection
  // ****************************************
  always_comb begin
    for (int c = 0; c < NB_CORES; c++) begin
      pending[c]   = buffer_o[c] & mask_i[c];
      irq_req_o[c] = |pending[c];
      irq_id_o[c]  = '0;
      // walk down so the lowest pending index is left
      for (int b = cluster_periph_pkg::EVT_W - 1; b >= 0; b--) begin
        if (pending[c][b]) begin
          irq_id_o[c] = b[cluster_periph_pkg::IRQ_ID_W-1:0];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/cluster_peripherals.sv
// cluster peripheral subsystem top: control unit, timer and event unit behind bus ports
`default_nettype none

module cluster_peripherals #(
  parameter int unsigned                            NB_CORES  = 4,
  parameter logic [cluster_periph_pkg::ADDR_W-1:0] BOOT_ADDR = 32'h1C000000
) (
  input  logic                                                   clk_i,
  input  logic                                                   arst_n_i,
  input  logic                                                   fetch_en_i,
  input  logic                                                   ref_tick_i,
  input  cluster_periph_pkg::periph_req_t                        ctrl_req_i,
  input  cluster_periph_pkg::periph_req_t                        timer_req_i,
  input  cluster_periph_pkg::periph_req_t [1:0]                  eu_req_i,
  input  logic [NB_CORES-1:0][cluster_periph_pkg::EVT_ACC_W-1:0] hwpe_events_i,
  input  logic                                                   dma_cl_event_i,
  input  logic                                                   dma_cl_irq_i,
  input  logic [NB_CORES-1:0]                                    irq_ack_i,
  input  logic [NB_CORES-1:0][cluster_periph_pkg::IRQ_ID_W-1:0]  irq_ack_id_i,
  output cluster_periph_pkg::periph_rsp_t                        ctrl_rsp_o,
  output cluster_periph_pkg::periph_rsp_t                        timer_rsp_o,
  output cluster_periph_pkg::periph_rsp_t [1:0]                  eu_rsp_o,
  output logic                                                   eoc_o,
  output logic [NB_CORES-1:0]                                    fetch_enable_reg_o,
  output logic [NB_CORES-1:0][cluster_periph_pkg::ADDR_W-1:0]    boot_addr_o,
  output logic                                                   busy_o,
  output logic [NB_CORES-1:0]                                    irq_req_o,
  output logic [NB_CORES-1:0][cluster_periph_pkg::IRQ_ID_W-1:0]  irq_id_o
);

  logic                                        timer_enable;
  logic                                        timer_clear;
  logic [cluster_periph_pkg::DATA_W-1:0]       timer_cmp;
  logic [cluster_periph_pkg::DATA_W-1:0]       timer_count;
  logic                                        timer_event;
  cluster_periph_pkg::evt_vec_t [NB_CORES-1:0] evt_set;
  cluster_periph_pkg::evt_vec_t [NB_CORES-1:0] eu_mask;
  cluster_periph_pkg::evt_vec_t [NB_CORES-1:0] eu_clear;
  cluster_periph_pkg::evt_vec_t [NB_CORES-1:0] eu_buffer;
  logic [NB_CORES-1:0]                         eu_sw_evt;

  // ****************************************
  // control unit
  // ****************************************
  cluster_ctrl_regs #(
    .NB_CORES  ( NB_CORES  ),
    .BOOT_ADDR ( BOOT_ADDR )
  ) cluster_ctrl_regs_inst (
    .clk_i          ( clk_i              ),
    .arst_n_i       ( arst_n_i           ),
    .fetch_en_i     ( fetch_en_i         ),
    .req_i          ( ctrl_req_i         ),
    .rsp_o          ( ctrl_rsp_o         ),
    .eoc_o          ( eoc_o              ),
    .fetch_enable_o ( fetch_enable_reg_o ),
    .boot_addr_o    ( boot_addr_o        )
  );

  // ****************************************
  // timer
  // ****************************************
  cluster_timer_regs cluster_timer_regs_inst (
    .clk_i    ( clk_i        ),
    .arst_n_i ( arst_n_i     ),
    .req_i    ( timer_req_i  ),
    .count_i  ( timer_count  ),
    .rsp_o    ( timer_rsp_o  ),
    .enable_o ( timer_enable ),
    .clear_o  ( timer_clear  ),
    .cmp_o    ( timer_cmp    )
  );

  cluster_timer_counter cluster_timer_counter_inst (
    .clk_i    ( clk_i        ),
    .arst_n_i ( arst_n_i     ),
    .enable_i ( timer_enable ),
    .clear_i  ( timer_clear  ),
    .tick_i   ( ref_tick_i   ),
    .cmp_i    ( timer_cmp    ),
    .count_o  ( timer_count  ),
    .event_o  ( timer_event  ),
    .busy_o   ( busy_o       )
  );

  // ****************************************
  // event unit
  // ****************************************
  // dma and timer events are shared by all cores, accelerator events are per core
  always_comb begin
    for (int c = 0; c < NB_CORES; c++) begin
      evt_set[c] = '0;
      evt_set[c][cluster_periph_pkg::EVT_ACC_LSB +: cluster_periph_pkg::EVT_ACC_W] =
        hwpe_events_i[c];
      evt_set[c][cluster_periph_pkg::EVT_DMA_EVT] = dma_cl_event_i;
      evt_set[c][cluster_periph_pkg::EVT_DMA_IRQ] = dma_cl_irq_i;
      evt_set[c][cluster_periph_pkg::EVT_TIMER]   = timer_event;
    end
  end

  event_unit_regs #(
    .NB_CORES ( NB_CORES )
  ) event_unit_regs_inst (
    .clk_i      ( clk_i     ),
    .arst_n_i   ( arst_n_i  ),
    .plug_req_i ( eu_req_i  ),
    .buffer_i   ( eu_buffer ),
    .plug_rsp_o ( eu_rsp_o  ),
    .mask_o     ( eu_mask   ),
    .clear_o    ( eu_clear  ),
    .sw_evt_o   ( eu_sw_evt )
  );

  event_unit_core #(
    .NB_CORES ( NB_CORES )
  ) event_unit_core_inst (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .evt_set_i    ( evt_set      ),
    .sw_evt_i     ( eu_sw_evt    ),
    .clear_i      ( eu_clear     ),
    .mask_i       ( eu_mask      ),
    .irq_ack_i    ( irq_ack_i    ),
    .irq_ack_id_i ( irq_ack_id_i ),
    .buffer_o     ( eu_buffer    ),
    .irq_req_o    ( irq_req_o    ),
    .irq_id_o     ( irq_id_o     )
  );

endmodule

`default_nettype wire

//--- include/tb_checks.svh
// compare tasks and the bus access task, included inside the testbench top module
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// full response check where writes expect zero data
task automatic check_rsp(input cluster_periph_pkg::periph_rsp_t got,
                         input logic [cluster_periph_pkg::ID_W-1:0] exp_id,
                         input logic [cluster_periph_pkg::DATA_W-1:0] exp_data,
                         input string what);
  if (got.r_valid !== 1'b1) begin
    $display("Mismatch at %0t: %s r_valid low one cycle after grant", $time, what);
    fail_run();
  end
  if (got.r_id !== exp_id) begin
    $display("Mismatch at %0t: %s r_id got %0d expected %0d", $time, what, got.r_id, exp_id);
    fail_run();
  end
  if (got.r_rdata !== exp_data) begin
    $display("Mismatch at %0t: %s r_rdata got %h expected %h", $time, what, got.r_rdata,
             exp_data);
    fail_run();
  end
endtask

task automatic check_word(input logic [cluster_periph_pkg::DATA_W-1:0] got,
                          input logic [cluster_periph_pkg::DATA_W-1:0] exp,
                          input string what);
  if (got !== exp) begin
    $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    fail_run();
  end
endtask

task automatic check_irq_id(input logic [cluster_periph_pkg::IRQ_ID_W-1:0] got,
                            input logic [cluster_periph_pkg::IRQ_ID_W-1:0] exp,
                            input string what);
  if (got !== exp) begin
    $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
    fail_run();
  end
endtask

// holds the request until granted, then checks the response one cycle later
task automatic bus_access(input int port, input logic wen, input logic [7:0] offset,
                          input logic [cluster_periph_pkg::ID_W-1:0] id,
                          input logic [cluster_periph_pkg::DATA_W-1:0] wdata,
                          input logic [cluster_periph_pkg::DATA_W-1:0] exp);
  cluster_periph_pkg::periph_req_t r;
  cluster_periph_pkg::periph_rsp_t rsp;
  logic granted;
  r       = '0;
  r.req   = 1'b1;
  r.addr  = {24'h0, offset};
  r.wen   = wen;
  r.wdata = wdata;
  r.id    = id;
  granted = 1'b0;
  while (!granted) begin
    @(negedge clk);
    drive_req(port, r);
    #1;
    rsp     = rsp_of(port);
    granted = rsp.gnt;
  end
  @(negedge clk);
  check_rsp(rsp_of(port), id, wen ? exp : '0, "bus response");
  // the other event unit plug must stay silent
  if (port >= PORT_EU0) begin
    rsp = rsp_of(PORT_EU0 + PORT_EU1 - port);
    check_word({31'b0, rsp.r_valid}, '0, "other plug r_valid");
  end
  drive_req(port, '0);
endtask

`endif

//--- verif/tb_cluster_peripherals.sv
// testbench for the cluster peripherals, applies a table of bus, event and timer steps
`default_nettype none

module tb_cluster_peripherals;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NB_CORES = 4;
  localparam logic [31:0] BOOT_ADDR = 32'h1C000000;

  localparam int PORT_CTRL = 0;
  localparam int PORT_TIMER = 1;
  localparam int PORT_EU0 = 2;
  localparam int PORT_EU1 = 3;

  // output selectors for OUT steps
  localparam logic [7:0] OUT_EOC = 8'd0;
  localparam logic [7:0] OUT_FETCH = 8'd1;
  localparam logic [7:0] OUT_BUSY = 8'd2;
  localparam logic [7:0] OUT_BOOT = 8'd3;

  typedef enum {K_BUS, K_EVT, K_TICK, K_ACK, K_IRQ, K_OUT, K_FETCH, K_MERGE} step_kind_e;

  typedef struct {
    step_kind_e  kind;
    int          port;
    logic        wen;
    logic [7:0]  offset;
    logic [3:0]  id;
    logic [31:0] wdata;
    logic [31:0] exp;
    logic [31:0] exp2;
  } step_t;

  logic clk;
  logic arst_n;
  logic fetch_en;
  logic ref_tick;
  cluster_periph_pkg::periph_req_t       ctrl_req;
  cluster_periph_pkg::periph_req_t       timer_req;
  cluster_periph_pkg::periph_req_t [1:0] eu_req;
  logic [NB_CORES-1:0][3:0]              hwpe_events;
  logic                                  dma_event;
  logic                                  dma_irq;
  logic [NB_CORES-1:0]                   irq_ack;
  logic [NB_CORES-1:0][4:0]              irq_ack_id;
  cluster_periph_pkg::periph_rsp_t       ctrl_rsp;
  cluster_periph_pkg::periph_rsp_t       timer_rsp;
  cluster_periph_pkg::periph_rsp_t [1:0] eu_rsp;
  logic                                  eoc;
  logic [NB_CORES-1:0]                   fetch_enable;
  logic [NB_CORES-1:0][31:0]             boot_addr;
  logic                                  busy;
  logic [NB_CORES-1:0]                   irq_req;
  logic [NB_CORES-1:0][4:0]              irq_id;

  step_t steps[$];
  int    cycles;
  int    cycle_limit;

  cluster_peripherals #(
    .NB_CORES  ( NB_CORES  ),
    .BOOT_ADDR ( BOOT_ADDR )
  ) cluster_peripherals_inst (
    .clk_i              ( clk          ),
    .arst_n_i           ( arst_n       ),
    .fetch_en_i         ( fetch_en     ),
    .ref_tick_i         ( ref_tick     ),
    .ctrl_req_i         ( ctrl_req     ),
    .timer_req_i        ( timer_req    ),
    .eu_req_i           ( eu_req       ),
    .hwpe_events_i      ( hwpe_events  ),
    .dma_cl_event_i     ( dma_event    ),
    .dma_cl_irq_i       ( dma_irq      ),
    .irq_ack_i          ( irq_ack      ),
    .irq_ack_id_i       ( irq_ack_id   ),
    .ctrl_rsp_o         ( ctrl_rsp     ),
    .timer_rsp_o        ( timer_rsp    ),
    .eu_rsp_o           ( eu_rsp       ),
    .eoc_o              ( eoc          ),
    .fetch_enable_reg_o ( fetch_enable ),
    .boot_addr_o        ( boot_addr    ),
    .busy_o             ( busy         ),
    .irq_req_o          ( irq_req      ),
    .irq_id_o           ( irq_id       )
  );

  always #2 clk = ~clk;

  task automatic fail_run();
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic drive_req(input int port, input cluster_periph_pkg::periph_req_t r);
    case (port)
      PORT_CTRL:  ctrl_req = r;
      PORT_TIMER: timer_req = r;
      PORT_EU0:   eu_req[0] = r;
      default:    eu_req[1] = r;
    endcase
  endtask

  function automatic cluster_periph_pkg::periph_rsp_t rsp_of(input int port);
    case (port)
      PORT_CTRL:  return ctrl_rsp;
      PORT_TIMER: return timer_rsp;
      PORT_EU0:   return eu_rsp[0];
      default:    return eu_rsp[1];
    endcase
  endfunction

  `include "tb_checks.svh"

  task automatic add_step(input step_kind_e kind, input int port, input logic wen,
                          input logic [7:0] offset, input logic [3:0] id,
                          input logic [31:0] wdata, input logic [31:0] exp,
                          input logic [31:0] exp2);
    step_t s;
    s.kind   = kind;
    s.port   = port;
    s.wen    = wen;
    s.offset = offset;
    s.id     = id;
    s.wdata  = wdata;
    s.exp    = exp;
    s.exp2   = exp2;
    steps.push_back(s);
  endtask

  // both plugs request in one cycle and plug 1 retries after plug 0
  task automatic merge_access(input step_t s);
    cluster_periph_pkg::periph_req_t r0;
    cluster_periph_pkg::periph_req_t r1;
    r0 = '0;
    r0.req = 1'b1;
    r0.addr = {24'h0, s.offset};
    r0.wen = s.wen;
    r0.id = s.id;
    r1 = r0;
    r1.id = s.wdata[3:0];
    @(negedge clk);
    eu_req[0] = r0;
    eu_req[1] = r1;
    #1;
    check_word({31'b0, eu_rsp[0].gnt}, 32'd1, "plug 0 gnt in collision");
    check_word({31'b0, eu_rsp[1].gnt}, 32'd0, "plug 1 gnt in collision");
    @(negedge clk);
    check_rsp(eu_rsp[0], r0.id, s.exp, "plug 0 response");
    check_word({31'b0, eu_rsp[1].r_valid}, 32'd0, "plug 1 r_valid after collision");
    eu_req[0] = '0;
    #1;
    check_word({31'b0, eu_rsp[1].gnt}, 32'd1, "plug 1 gnt on retry");
    @(negedge clk);
    check_rsp(eu_rsp[1], r1.id, s.exp2, "plug 1 response");
    check_word({31'b0, eu_rsp[0].r_valid}, 32'd0, "plug 0 r_valid after retry");
    eu_req[1] = '0;
  endtask

  task automatic run_step(input step_t s);
    case (s.kind)
      K_BUS: bus_access(s.port, s.wen, s.offset, s.id, s.wdata, s.exp);
      K_MERGE: merge_access(s);
      K_EVT: begin
        @(negedge clk);
        hwpe_events[s.id] = s.wdata[3:0];
        dma_event = s.wdata[4];
        dma_irq = s.wdata[5];
        @(negedge clk);
        hwpe_events = '0;
        dma_event = 1'b0;
        dma_irq = 1'b0;
      end
      K_TICK: begin
        repeat (s.wdata) begin
          @(negedge clk);
          ref_tick = 1'b1;
        end
        @(negedge clk);
        ref_tick = 1'b0;
      end
      K_ACK: begin
        @(negedge clk);
        irq_ack[s.id] = 1'b1;
        irq_ack_id[s.id] = s.wdata[4:0];
        @(negedge clk);
        irq_ack = '0;
      end
      K_FETCH: begin
        @(negedge clk);
        fetch_en = 1'b1;
        @(negedge clk);
        fetch_en = 1'b0;
      end
      K_IRQ: begin
        @(negedge clk);
        check_word({31'b0, irq_req[s.id]}, s.exp, "irq_req");
        check_irq_id(irq_id[s.id], s.exp2[4:0], "irq_id");
      end
      default: begin
        @(negedge clk);
        case (s.offset)
          OUT_EOC:   check_word({31'b0, eoc}, s.exp, "eoc_o");
          OUT_FETCH: check_word({28'b0, fetch_enable}, s.exp, "fetch_enable_reg_o");
          OUT_BUSY:  check_word({31'b0, busy}, s.exp, "busy_o");
          default:   check_word(boot_addr[s.id], s.exp, "boot_addr_o");
        endcase
      end
    endcase
  endtask

  // ****************************************
  // stimulus table
  // ****************************************
  task automatic build_table();
    // control unit
    add_step(K_BUS, PORT_CTRL, 1, 8'h40, 0, 0, BOOT_ADDR, 0);
    add_step(K_BUS, PORT_CTRL, 1, 8'h4C, 0, 0, BOOT_ADDR, 0);
    add_step(K_BUS, PORT_CTRL, 0, 8'h44, 0, 32'h1C008000, 0, 0);
    add_step(K_BUS, PORT_CTRL, 1, 8'h44, 0, 0, 32'h1C008000, 0);
    add_step(K_OUT, 0, 0, OUT_BOOT, 1, 0, 32'h1C008000, 0);
    add_step(K_OUT, 0, 0, OUT_EOC, 0, 0, 0, 0);
    add_step(K_BUS, PORT_CTRL, 0, 8'h00, 0, 1, 0, 0);
    add_step(K_OUT, 0, 0, OUT_EOC, 0, 0, 1, 0);
    add_step(K_BUS, PORT_CTRL, 1, 8'h00, 0, 0, 1, 0);
    add_step(K_OUT, 0, 0, OUT_FETCH, 0, 0, 0, 0);
    add_step(K_FETCH, 0, 0, 0, 0, 0, 0, 0);
    add_step(K_OUT, 0, 0, OUT_FETCH, 0, 0, 32'hF, 0);
    add_step(K_BUS, PORT_CTRL, 1, 8'h08, 0, 0, 32'hF, 0);
    // timer with compare 5 wraps every sixth tick
    add_step(K_BUS, PORT_TIMER, 0, 8'h10, 0, 5, 0, 0);
    add_step(K_BUS, PORT_TIMER, 0, 8'h00, 0, 1, 0, 0);
    add_step(K_OUT, 0, 0, OUT_BUSY, 0, 0, 1, 0);
    add_step(K_TICK, 0, 0, 0, 0, 3, 0, 0);
    add_step(K_BUS, PORT_TIMER, 1, 8'h08, 0, 0, 3, 0);
    add_step(K_TICK, 0, 0, 0, 0, 3, 0, 0);
    add_step(K_BUS, PORT_TIMER, 1, 8'h08, 0, 0, 0, 0);
    add_step(K_BUS, PORT_EU0, 1, 8'h04, 0, 0, 32'h40, 0);
    add_step(K_BUS, PORT_EU0, 1, 8'h04, 3, 0, 32'h40, 0);
    add_step(K_TICK, 0, 0, 0, 0, 2, 0, 0);
    add_step(K_BUS, PORT_TIMER, 1, 8'h08, 0, 0, 2, 0);
    add_step(K_BUS, PORT_TIMER, 0, 8'h00, 0, 3, 0, 0);
    add_step(K_BUS, PORT_TIMER, 1, 8'h08, 0, 0, 0, 0);
    add_step(K_BUS, PORT_TIMER, 0, 8'h00, 0, 0, 0, 0);
    add_step(K_OUT, 0, 0, OUT_BUSY, 0, 0, 0, 0);
    add_step(K_BUS, PORT_TIMER, 1, 8'h00, 0, 0, 0, 0);
    // drop the timer bit of core 1 only
    add_step(K_BUS, PORT_EU0, 0, 8'h08, 1, 32'h40, 0, 0);
    add_step(K_BUS, PORT_EU0, 1, 8'h04, 1, 0, 0, 0);
    add_step(K_BUS, PORT_EU0, 1, 8'h04, 0, 0, 32'h40, 0);
    // accelerator bit 2 on core 1 plus a dma event for every core
    add_step(K_EVT, 0, 0, 0, 1, 32'h14, 0, 0);
    add_step(K_BUS, PORT_EU0, 1, 8'h04, 1, 0, 32'h14, 0);
    add_step(K_IRQ, 0, 0, 0, 1, 0, 0, 0);
    add_step(K_BUS, PORT_EU0, 0, 8'h00, 1, 32'hFF, 0, 0);
    add_step(K_BUS, PORT_EU0, 1, 8'h00, 1, 0, 32'hFF, 0);
    add_step(K_IRQ, 0, 0, 0, 1, 0, 1, 2);
    add_step(K_ACK, 0, 0, 0, 1, 2, 0, 0);
    add_step(K_IRQ, 0, 0, 0, 1, 0, 1, 4);
    add_step(K_ACK, 0, 0, 0, 1, 4, 0, 0);
    add_step(K_IRQ, 0, 0, 0, 1, 0, 0, 0);
    add_step(K_BUS, PORT_EU0, 1, 8'h04, 1, 0, 0, 0);
    // software events to cores 0 and 2
    add_step(K_BUS, PORT_EU0, 0, 8'h0C, 1, 32'h5, 0, 0);
    add_step(K_BUS, PORT_EU0, 1, 8'h04, 0, 0, 32'hD0, 0);
    add_step(K_BUS, PORT_EU0, 1, 8'h04, 1, 0, 32'h00, 0);
    add_step(K_BUS, PORT_EU0, 1, 8'h04, 2, 0, 32'hD0, 0);
    add_step(K_BUS, PORT_EU0, 1, 8'h04, 3, 0, 32'h50, 0);
    add_step(K_BUS, PORT_EU0, 0, 8'h08, 2, 32'h80, 0, 0);
    add_step(K_BUS, PORT_EU0, 1, 8'h04, 2, 0, 32'h50, 0);
    // plug merge with plug 1 carrying id 3 in wdata
    add_step(K_MERGE, 0, 1, 8'h04, 0, 32'h3, 32'hD0, 32'h50);
    add_step(K_BUS, PORT_EU1, 1, 8'h04, 2, 0, 32'h50, 0);
  endtask

  // run limit grows with the table
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      fail_run();
    end
  end

  initial begin
    clk = 1'b0;
    arst_n = 1'b0;
    fetch_en = 1'b0;
    ref_tick = 1'b0;
    ctrl_req = '0;
    timer_req = '0;
    eu_req = '0;
    hwpe_events = '0;
    dma_event = 1'b0;
    dma_irq = 1'b0;
    irq_ack = '0;
    irq_ack_id = '0;
    cycles = 0;
    cycle_limit = 0;
    build_table();
    cycle_limit = steps.size() * 40;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    foreach (steps[i]) begin
      run_step(steps[i]);
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
logic/cluster_periph_pkg.sv
logic/cluster_ctrl_regs.sv
logic/cluster_timer_regs.sv
logic/cluster_timer_counter.sv
logic/event_unit_regs.sv
logic/event_unit_core.sv
logic/cluster_peripherals.sv
verif/tb_cluster_peripherals.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cluster peripherals testbench with Verilator

LOG=sim.log

verilator --binary --timing -f tb.f --top-module tb_cluster_peripherals -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_cluster_peripherals > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
fi

if grep -q "RESULT: PASS" "$LOG"; then
  exit 0
fi
exit 1
